/* verilog.f */
hk_pkg.sv
hk_spi_shifter.sv
hk_spi_cmd_fsm.sv
hk_reg_file.sv
spi_sysctrl_wb.sv
hk_top.sv
hk_tb.sv

/* hk_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module hk_tb;

    localparam logic [31:0] BASE_ADR   = 32'h2E00_0000;
    localparam logic [11:0] MFGR_ID    = 12'hA5C;
    localparam logic [7:0]  PROD_ID    = 8'h3B;
    localparam logic [3:0]  MASK_REV   = 4'h9;
    localparam int          HALF_SCK   = 4;  // clk cycles per SCK half-period
    localparam int          WB_TIMEOUT = 20;

    logic            clk;
    logic            reset_i;
    logic            sck;
    logic            csb;
    logic            sdi;
    logic            sdo;
    logic [31:0]     wb_adr;
    logic [31:0]     wb_dat_w;
    logic [3:0]      wb_sel;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [31:0]     wb_dat_r;
    logic            wb_ack;
    hk_pkg::hk_cfg_t cfg;
    hk_pkg::hk_cfg_t model_cfg;
    logic [7:0]      wr_buf [0:15];
    logic [7:0]      rd_buf [0:15];
    int              mismatch_cnt;
    int              fail_cnt;

    hk_top #(
        .BASE_ADR (BASE_ADR),
        .MFGR_ID  (MFGR_ID),
        .PROD_ID  (PROD_ID),
        .MASK_REV (MASK_REV)
    ) i_hk_top (
        .clk      (clk),
        .reset_i  (reset_i),
        .sck_i    (sck),
        .csb_i    (csb),
        .sdi_i    (sdi),
        .sdo_o    (sdo),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .cfg_o    (cfg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // power-on settings: regulator and crystal on, PLL bypassed, divider 4
    function automatic hk_pkg::hk_cfg_t reset_cfg();
        hk_pkg::hk_cfg_t c;
        c            = '0;
        c.reg_ena    = 1'b1;
        c.xtal_ena   = 1'b1;
        c.pll_div    = 5'd4;
        c.pll_bypass = 1'b1;
        return c;
    endfunction

    // register map as seen by the SPI host
    function automatic hk_pkg::hk_cfg_t apply_write(input hk_pkg::hk_cfg_t c,
                                                    input logic [7:0] a, input logic [7:0] d);
        hk_pkg::hk_cfg_t n;
        n = c;
        case (a)
            8'h00: n.config_byte = d;
            8'h08: begin
                n.reg_ena  = d[0];
                n.xtal_ena = d[1];
                n.pll_sel  = d[4:2];
            end
            8'h09: n.pll_div = d[4:0];
            8'h0A: n.pll_trim[25:24] = d[1:0];
            8'h0B: n.pll_trim[23:16] = d;
            8'h0C: n.pll_trim[15:8] = d;
            8'h0D: n.pll_trim[7:0] = d;
            8'h0E: begin
                n.dco_ena    = d[0];
                n.pll_bypass = d[1];
            end
            default: n = c;
        endcase
        return n;
    endfunction

    function automatic logic [7:0] expect_byte(input hk_pkg::hk_cfg_t c, input logic [7:0] a);
        logic [7:0] b;
        b = 8'h00;
        case (a)
            8'h00: b = c.config_byte;
            8'h01: b[3:0] = MFGR_ID[11:8];
            8'h02: b = MFGR_ID[7:0];
            8'h03: b = PROD_ID;
            8'h04: b[3:0] = MASK_REV;
            8'h08: begin
                b[0]   = c.reg_ena;
                b[1]   = c.xtal_ena;
                b[4:2] = c.pll_sel;
            end
            8'h09: b[4:0] = c.pll_div;
            8'h0A: b[1:0] = c.pll_trim[25:24];
            8'h0B: b = c.pll_trim[23:16];
            8'h0C: b = c.pll_trim[15:8];
            8'h0D: b = c.pll_trim[7:0];
            8'h0E: b[1:0] = {c.pll_bypass, c.dco_ena};
            default: b = 8'h00;
        endcase
        return b;
    endfunction

    // word layout of the CPU view
    function automatic logic [31:0] expect_word(input hk_pkg::hk_cfg_t c, input logic [7:0] ofs);
        logic [31:0] w;
        w = 32'd0;
        case (ofs)
            8'h00: w[7:0] = c.config_byte;
            8'h04: begin
                w[0]   = c.reg_ena;
                w[1]   = c.xtal_ena;
                w[4:2] = c.pll_sel;
                w[9:5] = c.pll_div;
            end
            8'h08: begin
                w[0]    = c.dco_ena;
                w[26:1] = c.pll_trim;
            end
            8'h0C: w[11:0] = MFGR_ID;
            8'h10: w[7:0] = PROD_ID;
            8'h14: w[3:0] = MASK_REV;
            8'h18: w[0] = c.pll_bypass;
            default: w = 32'd0;
        endcase
        return w;
    endfunction

    task automatic cmp_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic cmp_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic cmp_cfg(input hk_pkg::hk_cfg_t got, input hk_pkg::hk_cfg_t exp,
                           input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t ns: %s got 0x%012h expected 0x%012h", $time, what, got, exp);
        end
    endtask

    // all SPI and Wishbone tasks start and end on a falling clk edge
    task automatic spi_begin();
        csb = 1'b0;
        repeat (HALF_SCK) @(negedge clk);
    endtask

    task automatic spi_end();
        sck = 1'b0;
        repeat (HALF_SCK) @(negedge clk);
        csb = 1'b1;
        repeat (2 * HALF_SCK) @(negedge clk);
    endtask

    task automatic spi_xfer_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        rx = 8'h00;
        for (int i = 7; i > 7 - nbits; i--) begin
            sck = 1'b0;
            sdi = tx[i];
            repeat (HALF_SCK) @(negedge clk);
            rx[i] = sdo;  // host samples SDO as it raises SCK
            sck = 1'b1;
            repeat (HALF_SCK) @(negedge clk);
        end
    endtask

    task automatic spi_xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        spi_xfer_bits(tx, 8, rx);
    endtask

    task automatic spi_write(input logic [7:0] addr, input int len);
        logic [7:0] rx;
        spi_begin();
        spi_xfer_byte(hk_pkg::OP_WRITE, rx);
        spi_xfer_byte(addr, rx);
        for (int k = 0; k < len; k++) begin
            spi_xfer_byte(wr_buf[k], rx);
            model_cfg = apply_write(model_cfg, addr + 8'(k), wr_buf[k]);
        end
        spi_end();
    endtask

    task automatic spi_read(input logic [7:0] addr, input int len);
        logic [7:0] rx;
        spi_begin();
        spi_xfer_byte(hk_pkg::OP_READ, rx);
        spi_xfer_byte(addr, rx);
        for (int k = 0; k < len; k++) begin
            spi_xfer_byte(8'h00, rd_buf[k]);
        end
        spi_end();
    endtask

    task automatic bus_cycle(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
                             output logic [31:0] rdat, output logic acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        rdat   = 32'd0;
        wb_adr   = adr;
        wb_we    = we;
        wb_dat_w = wdat;
        wb_sel   = 4'hF;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        while (!acked && waited < WB_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (wb_ack) begin
                acked = 1'b1;
                rdat  = wb_dat_r;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat, output logic acked);
        bus_cycle(adr, 1'b0, 32'd0, dat, acked);
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, output logic acked);
        logic [31:0] unused;
        bus_cycle(adr, 1'b1, dat, unused, acked);
    endtask

    task automatic check_wb(input string tag);
        logic [31:0] word;
        logic        acked;
        logic [7:0]  ofs;
        cmp_cfg(cfg, model_cfg, {tag, ": cfg_o"});
        for (int k = 0; k < 8; k++) begin
            ofs = 8'(4 * k);  // 0x1C is past the map and reads 0
            wb_read(BASE_ADR + {24'd0, ofs}, word, acked);
            if (!acked) begin
                fail_cnt++;
                $display("Error at %0t ns: %s, no Wishbone ack at offset 0x%02h", $time, tag, ofs);
            end else begin
                cmp_word(word, expect_word(model_cfg, ofs),
                         $sformatf("%s: wb offset 0x%02h", tag, ofs));
            end
        end
    endtask

    task automatic check_spi(input string tag);
        spi_read(8'h00, 15);
        for (int k = 0; k < 15; k++) begin
            cmp_byte(rd_buf[k], expect_byte(model_cfg, 8'(k)),
                     $sformatf("%s: spi byte 0x%02h", tag, k));
        end
    endtask

    task automatic reset_values();
        cmp_cfg(cfg, reset_cfg(), "reset: cfg_o");
        cmp_byte({7'd0, sdo}, 8'h00, "reset: sdo_o");
        cmp_byte({7'd0, wb_ack}, 8'h00, "reset: wb_ack_o");
        check_wb("reset");
    endtask

    task automatic write_each_reg();
        logic [7:0] addrs [0:7];
        addrs = '{8'h00, 8'h08, 8'h09, 8'h0A, 8'h0B, 8'h0C, 8'h0D, 8'h0E};
        for (int k = 0; k < 8; k++) begin
            wr_buf[0] = ~expect_byte(model_cfg, addrs[k]);  // every used bit flips, unused bits set
            spi_write(addrs[k], 1);
            check_wb($sformatf("write 0x%02h", addrs[k]));
        end
        for (int k = 0; k < 7; k++) begin
            wr_buf[k] = 8'hFF;
        end
        spi_write(8'h01, 7);  // IDs and the gap are read-only
        check_wb("write read-only");
    endtask

    task automatic wb_decode();
        logic [31:0] word;
        logic        acked;
        wb_read(32'h2F00_0004, word, acked);
        if (acked) begin
            fail_cnt++;
            $display("Error at %0t ns: Wishbone read at a wrong base was acked", $time);
        end
        wb_read(BASE_ADR + 32'h100, word, acked);
        if (acked) begin
            fail_cnt++;
            $display("Error at %0t ns: Wishbone read past the 256-byte window was acked", $time);
        end
        wb_write(BASE_ADR + 32'h4, 32'hFFFF_FFFF, acked);
        if (!acked) begin
            fail_cnt++;
            $display("Error at %0t ns: Wishbone write got no ack", $time);
        end
        cmp_cfg(cfg, model_cfg, "after wb write: cfg_o");
    endtask

    task automatic random_streams();
        int start;
        int len;
        for (int n = 0; n < 20; n++) begin
            start = $urandom_range(14, 0);
            len   = $urandom_range(15 - start, 1);
            for (int k = 0; k < len; k++) begin
                wr_buf[k] = 8'($urandom);
            end
            spi_write(8'(start), len);
            check_wb($sformatf("random %0d", n));
            check_spi($sformatf("random %0d", n));
        end
    endtask

    task automatic bad_transactions();
        logic [7:0] rx;
        spi_begin();
        spi_xfer_byte(8'h20, rx);
        spi_xfer_byte(8'h00, rx);
        spi_xfer_byte(~model_cfg.config_byte, rx);
        spi_xfer_byte(8'hA5, rx);
        spi_end();
        cmp_cfg(cfg, model_cfg, "unknown opcode: cfg_o");
        spi_begin();
        spi_xfer_byte(hk_pkg::OP_WRITE, rx);
        spi_xfer_byte(8'h0D, rx);
        spi_xfer_bits(~model_cfg.pll_trim[7:0], 4, rx);
        spi_end();  // CSB rises halfway through the data byte
        cmp_cfg(cfg, model_cfg, "aborted byte: cfg_o");
        wr_buf[0] = 8'h6C;
        spi_write(8'h0D, 1);
        check_wb("after abort");
        check_spi("after abort");
    endtask

    initial begin
        void'($urandom(70961));
        mismatch_cnt = 0;
        fail_cnt     = 0;
        reset_i  = 1'b1;
        sck      = 1'b0;
        csb      = 1'b1;
        sdi      = 1'b0;
        wb_adr   = 32'd0;
        wb_dat_w = 32'd0;
        wb_sel   = 4'h0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        model_cfg = reset_cfg();
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        repeat (2) @(negedge clk);
        reset_values();
        write_each_reg();
        check_spi("stream read");
        wb_decode();
        random_streams();
        bad_transactions();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hk_top.sv */
`timescale 1ns/1ns
`default_nettype none

module hk_top #(
    parameter logic [31:0] BASE_ADR = 32'h2E00_0000,
    parameter logic [11:0] MFGR_ID  = 12'h456,
    parameter logic [7:0]  PROD_ID  = 8'h11,
    parameter logic [3:0]  MASK_REV = 4'h3
) (
    input  wire             clk,
    input  wire             reset_i,
    input  wire             sck_i,
    input  wire             csb_i,
    input  wire             sdi_i,
    output logic            sdo_o,
    input  wire  [31:0]     wb_adr_i,
    input  wire  [31:0]     wb_dat_i,
    input  wire  [3:0]      wb_sel_i,
    input  wire             wb_cyc_i,
    input  wire             wb_stb_i,
    input  wire             wb_we_i,
    output logic [31:0]     wb_dat_o,
    output logic            wb_ack_o,
    output hk_pkg::hk_cfg_t cfg_o
);

    logic                 byte_valid;
    logic                 csb_rise;
    logic [7:0]           rx_byte;
    logic                 tx_load;
    logic [7:0]           tx_byte;
    hk_pkg::hk_reg_addr_e reg_addr;
    logic                 reg_wr;
    logic [7:0]           reg_wdata;
    logic [7:0]           reg_rdata;

    hk_spi_shifter i_shifter (
        .clk          (clk),
        .reset_i      (reset_i),
        .sck_i        (sck_i),
        .csb_i        (csb_i),
        .sdi_i        (sdi_i),
        .tx_load_i    (tx_load),
        .tx_byte_i    (tx_byte),
        .sdo_o        (sdo_o),
        .byte_valid_o (byte_valid),
        .rx_byte_o    (rx_byte),
        .csb_rise_o   (csb_rise)
    );

    hk_spi_cmd_fsm i_cmd_fsm (
        .clk          (clk),
        .reset_i      (reset_i),
        .byte_valid_i (byte_valid),
        .csb_rise_i   (csb_rise),
        .rx_byte_i    (rx_byte),
        .reg_rdata_i  (reg_rdata),
        .reg_addr_o   (reg_addr),
        .reg_wr_o     (reg_wr),
        .reg_wdata_o  (reg_wdata),
        .tx_load_o    (tx_load),
        .tx_byte_o    (tx_byte)
    );

    hk_reg_file #(
        .MFGR_ID  (MFGR_ID),
        .PROD_ID  (PROD_ID),
        .MASK_REV (MASK_REV)
    ) i_reg_file (
        .clk     (clk),
        .reset_i (reset_i),
        .wr_i    (reg_wr),
        .addr_i  (reg_addr),
        .wdata_i (reg_wdata),
        .rdata_o (reg_rdata),
        .cfg_o   (cfg_o)
    );

    spi_sysctrl_wb #(
        .BASE_ADR (BASE_ADR),
        .MFGR_ID  (MFGR_ID),
        .PROD_ID  (PROD_ID),
        .MASK_REV (MASK_REV)
    ) i_sysctrl_wb (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .cfg_i    (cfg_o)
    );

endmodule

`default_nettype wire

/* spi_sysctrl_wb.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_sysctrl_wb #(
    parameter logic [31:0] BASE_ADR = 32'h2E00_0000,
    parameter logic [11:0] MFGR_ID  = 12'h456,
    parameter logic [7:0]  PROD_ID  = 8'h11,
    parameter logic [3:0]  MASK_REV = 4'h3
) (
    input  wire             clk,
    input  wire             reset_i,
    input  wire  [31:0]     wb_adr_i,
    input  wire  [31:0]     wb_dat_i,
    input  wire  [3:0]      wb_sel_i,
    input  wire             wb_cyc_i,
    input  wire             wb_stb_i,
    input  wire             wb_we_i,
    output logic [31:0]     wb_dat_o,
    output logic            wb_ack_o,
    input  wire hk_pkg::hk_cfg_t cfg_i
);

    localparam logic [7:0] OFS_CONFIG = 8'h00;
    localparam logic [7:0] OFS_ENA    = 8'h04;
    localparam logic [7:0] OFS_PLL    = 8'h08;
    localparam logic [7:0] OFS_MFGR   = 8'h0C;
    localparam logic [7:0] OFS_PROD   = 8'h10;
    localparam logic [7:0] OFS_MASK   = 8'h14;
    localparam logic [7:0] OFS_BYPASS = 8'h18;

    logic        hit;
    logic [31:0] rd_word;

    // the !wb_ack_o term forces one idle cycle after every ack
    assign hit = wb_cyc_i && wb_stb_i && !wb_ack_o &&
                 (wb_adr_i[31:8] == BASE_ADR[31:8]);

    always_comb begin
        rd_word = 32'd0;
        case (wb_adr_i[7:0])
            OFS_CONFIG: rd_word = {24'd0, cfg_i.config_byte};
            OFS_ENA: begin
                rd_word = {22'd0, cfg_i.pll_div, cfg_i.pll_sel,
                           cfg_i.xtal_ena, cfg_i.reg_ena};
            end
            OFS_PLL:    rd_word = {5'd0, cfg_i.pll_trim, cfg_i.dco_ena};
            OFS_MFGR:   rd_word = {20'd0, MFGR_ID};
            OFS_PROD:   rd_word = {24'd0, PROD_ID};
            OFS_MASK:   rd_word = {28'd0, MASK_REV};
            OFS_BYPASS: rd_word = {31'd0, cfg_i.pll_bypass};
            default:    rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= hit;
        end
    end

    // writes get the same ack but wb_dat_i and wb_sel_i go nowhere
    always_ff @(posedge clk) begin
        if (hit) begin
            wb_dat_o <= wb_we_i ? 32'd0 : rd_word;
        end
    end

endmodule

`default_nettype wire

/* hk_reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module hk_reg_file #(
    parameter logic [11:0] MFGR_ID  = 12'h456,
    parameter logic [7:0]  PROD_ID  = 8'h11,
    parameter logic [3:0]  MASK_REV = 4'h3
) (
    input  wire             clk,
    input  wire             reset_i,
    input  wire             wr_i,
    input  wire  [7:0]      addr_i,
    input  wire  [7:0]      wdata_i,
    output logic [7:0]      rdata_o,
    output hk_pkg::hk_cfg_t cfg_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o <= hk_pkg::HK_CFG_RESET;
        end else if (wr_i) begin
            case (addr_i)
                hk_pkg::RA_CONFIG: begin
                    cfg_o.config_byte <= wdata_i;
                end
                hk_pkg::RA_ENA: begin
                    cfg_o.reg_ena  <= wdata_i[0];
                    cfg_o.xtal_ena <= wdata_i[1];
                    cfg_o.pll_sel  <= wdata_i[4:2];
                end
                hk_pkg::RA_PLL_DIV: begin
                    cfg_o.pll_div <= wdata_i[4:0];
                end
                hk_pkg::RA_TRIM3: begin
                    cfg_o.pll_trim[25:24] <= wdata_i[1:0];
                end
                hk_pkg::RA_TRIM2: begin
                    cfg_o.pll_trim[23:16] <= wdata_i;
                end
                hk_pkg::RA_TRIM1: begin
                    cfg_o.pll_trim[15:8] <= wdata_i;
                end
                hk_pkg::RA_TRIM0: begin
                    cfg_o.pll_trim[7:0] <= wdata_i;
                end
                hk_pkg::RA_PLL_CTRL: begin
                    cfg_o.dco_ena    <= wdata_i[0];
                    cfg_o.pll_bypass <= wdata_i[1];
                end
                default: begin
                    cfg_o <= cfg_o;  // ID bytes and gaps are not writable
                end
            endcase
        end
    end

    always_comb begin
        rdata_o = 8'h00;
        case (addr_i)
            hk_pkg::RA_CONFIG:   rdata_o = cfg_o.config_byte;
            hk_pkg::RA_MFGR_HI:  rdata_o = {4'h0, MFGR_ID[11:8]};
            hk_pkg::RA_MFGR_LO:  rdata_o = MFGR_ID[7:0];
            hk_pkg::RA_PROD:     rdata_o = PROD_ID;
            hk_pkg::RA_MASK:     rdata_o = {4'h0, MASK_REV};
            hk_pkg::RA_ENA: begin
                rdata_o = {3'b000, cfg_o.pll_sel, cfg_o.xtal_ena, cfg_o.reg_ena};
            end
            hk_pkg::RA_PLL_DIV:  rdata_o = {3'b000, cfg_o.pll_div};
            hk_pkg::RA_TRIM3:    rdata_o = {6'd0, cfg_o.pll_trim[25:24]};
            hk_pkg::RA_TRIM2:    rdata_o = cfg_o.pll_trim[23:16];
            hk_pkg::RA_TRIM1:    rdata_o = cfg_o.pll_trim[15:8];
            hk_pkg::RA_TRIM0:    rdata_o = cfg_o.pll_trim[7:0];
            hk_pkg::RA_PLL_CTRL: rdata_o = {6'd0, cfg_o.pll_bypass, cfg_o.dco_ena};
            default:             rdata_o = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* hk_spi_cmd_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module hk_spi_cmd_fsm (
    input  wire                  clk,
    input  wire                  reset_i,
    input  wire                  byte_valid_i,
    input  wire                  csb_rise_i,
    input  wire  [7:0]           rx_byte_i,
    input  wire  [7:0]           reg_rdata_i,
    output hk_pkg::hk_reg_addr_e reg_addr_o,
    output logic                 reg_wr_o,
    output logic [7:0]           reg_wdata_o,
    output logic                 tx_load_o,
    output logic [7:0]           tx_byte_o
);

    hk_pkg::hk_state_e    state_q;
    hk_pkg::hk_state_e    state_d;
    hk_pkg::hk_opcode_e   opcode_q;
    hk_pkg::hk_opcode_e   rx_op;
    hk_pkg::hk_reg_addr_e addr_q;
    hk_pkg::hk_reg_addr_e addr_inc;
    logic                 op_known;
    logic                 load_q;

    assign rx_op    = hk_pkg::hk_opcode_e'(rx_byte_i);
    assign addr_inc = hk_pkg::hk_reg_addr_e'(addr_q + 8'd1);

    always_comb begin
        case (rx_op)
            hk_pkg::OP_WRITE,
            hk_pkg::OP_READ: op_known = 1'b1;
            default:         op_known = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        if (csb_rise_i) begin
            state_d = hk_pkg::ST_IDLE;  // CSB high ends any transaction
        end else if (byte_valid_i) begin
            case (state_q)
                hk_pkg::ST_IDLE: begin
                    state_d = op_known ? hk_pkg::ST_ADDR : hk_pkg::ST_IGNORE;
                end
                hk_pkg::ST_ADDR: begin
                    if (opcode_q == hk_pkg::OP_WRITE) begin
                        state_d = hk_pkg::ST_WRITE;
                    end else begin
                        state_d = hk_pkg::ST_READ;
                    end
                end
                default: state_d = state_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= hk_pkg::ST_IDLE;
            opcode_q <= hk_pkg::OP_READ;
            addr_q   <= hk_pkg::RA_CONFIG;
            load_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            load_q  <= 1'b0;
            if (byte_valid_i && !csb_rise_i) begin
                case (state_q)
                    hk_pkg::ST_IDLE: begin
                        opcode_q <= rx_op;
                    end
                    hk_pkg::ST_ADDR: begin
                        addr_q <= hk_pkg::hk_reg_addr_e'(rx_byte_i);
                        load_q <= (opcode_q == hk_pkg::OP_READ);  // first read byte
                    end
                    hk_pkg::ST_WRITE: begin
                        addr_q <= addr_inc;
                    end
                    hk_pkg::ST_READ: begin
                        addr_q <= addr_inc;
                        load_q <= 1'b1;
                    end
                    default: begin
                        addr_q <= addr_q;
                    end
                endcase
            end
        end
    end

    assign reg_addr_o  = addr_q;
    assign reg_wr_o    = byte_valid_i && (state_q == hk_pkg::ST_WRITE);
    assign reg_wdata_o = rx_byte_i;

    // load one clk after the byte so reg_rdata_i already reflects the new address
    assign tx_load_o = load_q;
    assign tx_byte_o = reg_rdata_i;

endmodule

`default_nettype wire

/* hk_spi_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module hk_spi_shifter (
    input  wire        clk,
    input  wire        reset_i,
    input  wire        sck_i,
    input  wire        csb_i,
    input  wire        sdi_i,
    input  wire        tx_load_i,
    input  wire  [7:0] tx_byte_i,
    output logic       sdo_o,
    output logic       byte_valid_o,
    output logic [7:0] rx_byte_o,
    output logic       csb_rise_o
);

    logic [1:0] sck_sync;
    logic [1:0] csb_sync;
    logic [1:0] sdi_sync;
    logic       sck_q;
    logic       csb_q;
    logic       sck_rise;
    logic       sck_fall;
    logic       csb_high;
    logic [2:0] bit_cnt;
    logic [7:0] tx_shift;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sck_sync <= 2'b00;
            csb_sync <= 2'b11;  // idle bus has CSB high
            sdi_sync <= 2'b00;
            sck_q    <= 1'b0;
            csb_q    <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[0], sck_i};
            csb_sync <= {csb_sync[0], csb_i};
            sdi_sync <= {sdi_sync[0], sdi_i};
            sck_q    <= sck_sync[1];
            csb_q    <= csb_sync[1];
        end
    end

    assign sck_rise   = sck_sync[1] & ~sck_q;
    assign sck_fall   = ~sck_sync[1] & sck_q;
    assign csb_high   = csb_sync[1];
    assign csb_rise_o = csb_sync[1] & ~csb_q;

    always_ff @(posedge clk) begin
        if (reset_i || csb_high) begin
            bit_cnt      <= 3'd0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= sck_rise && (bit_cnt == 3'd7);
            if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // holds the completed byte until the next rising SCK of the following byte
    always_ff @(posedge clk) begin
        if (sck_rise && !csb_high) begin
            rx_byte_o <= {rx_byte_o[6:0], sdi_sync[1]};
        end
    end

    // no shift on the fall that closes a byte, so a freshly loaded MSB stays on SDO
    always_ff @(posedge clk) begin
        if (reset_i || csb_high) begin
            tx_shift <= 8'h00;
        end else if (tx_load_i) begin
            tx_shift <= tx_byte_i;
        end else if (sck_fall && (bit_cnt != 3'd0)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign sdo_o = tx_shift[7];

endmodule

`default_nettype wire

/* hk_pkg.sv */
`default_nettype none

package hk_pkg;

    // SPI command byte, anything else puts the FSM in ST_IGNORE
    typedef enum logic [7:0] {
        OP_WRITE = 8'h80,
        OP_READ  = 8'h40
    } hk_opcode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WRITE,
        ST_READ,
        ST_IGNORE
    } hk_state_e;

    typedef enum logic [7:0] {
        RA_CONFIG   = 8'h00,
        RA_MFGR_HI  = 8'h01,
        RA_MFGR_LO  = 8'h02,
        RA_PROD     = 8'h03,
        RA_MASK     = 8'h04,
        RA_ENA      = 8'h08,
        RA_PLL_DIV  = 8'h09,
        RA_TRIM3    = 8'h0A,
        RA_TRIM2    = 8'h0B,
        RA_TRIM1    = 8'h0C,
        RA_TRIM0    = 8'h0D,
        RA_PLL_CTRL = 8'h0E
    } hk_reg_addr_e;

    // the config field is named config_byte since config is a keyword
    typedef struct packed {
        logic [7:0]  config_byte;
        logic [4:0]  pll_div;
        logic [2:0]  pll_sel;
        logic        xtal_ena;
        logic        reg_ena;
        logic [25:0] pll_trim;
        logic        dco_ena;
        logic        pll_bypass;
    } hk_cfg_t;

    localparam hk_cfg_t HK_CFG_RESET = '{
        config_byte: 8'h00,
        pll_div:     5'd4,
        pll_sel:     3'd0,
        xtal_ena:    1'b1,
        reg_ena:     1'b1,
        pll_trim:    26'd0,
        dco_ena:     1'b0,
        pll_bypass:  1'b1
    };

endpackage

`default_nettype wire
